// File: include/mio_defs.svh
`ifndef MIO_DEFS_SVH
`define MIO_DEFS_SVH

// Mesh address and packet widths
`define MIO_AW 32
`define MIO_PW (2*`MIO_AW+40)

// Link width and bytes per packet
`define MIO_NMIO 8
`define MIO_BEATS (`MIO_PW/`MIO_NMIO)

//########################################
// Register offsets in dstaddr[7:0]
//########################################
`define MIO_REG_CFG     8'h00
`define MIO_REG_STATUS  8'h04
`define MIO_REG_SCRATCH 8'h08

// CFG after reset
// Bit 0 is transmit enable
`define MIO_DEF_CFG 32'h0000_0001

`endif

// File: hdl/emesh_pkg.sv
`include "mio_defs.svh"

package emesh_pkg;

   //########################################
   // Field vectors
   //########################################

   typedef logic [`MIO_AW-1:0] addr_t;   // Mesh address
   typedef logic [31:0]        data_t;   // Data word
   typedef logic [3:0]         ctrl_t;   // Control mode
   typedef logic [1:0]         mode_t;   // Data mode (size)

   //########################################
   // Mesh packet
   //########################################

   // MSB first, 104 bits in all
   // dstaddr lands on packet bits 39:8
   typedef struct packed {
      addr_t srcaddr;    // Return address for reads
      data_t data;       // Write data or read result
      addr_t dstaddr;    // Target, bits 31:20 pick the path
      ctrl_t ctrlmode;
      mode_t datamode;
      logic  write;      // 1 write, 0 read
      logic  spare;      // Pads the low byte to 8
   } packet_t;

endpackage

// File: hdl/mio_pkg.sv
`include "mio_defs.svh"

package mio_pkg;

   //########################################
   // Link side
   //########################################

   typedef logic [`MIO_NMIO-1:0] link_byte_t;   // One link beat
   typedef logic [3:0]           beat_t;        // Beat index, 0..12

   // Serializer FSM
   typedef enum logic {
      TX_IDLE,   // Waiting for a packet
      TX_SEND    // Shifting bytes onto the link
   } tx_state_t;

   // Deserializer FSM
   typedef enum logic {
      RX_COLLECT,   // Taking bytes
      RX_HOLD       // Full packet on the output
   } rx_state_t;

endpackage

// File: hdl/mio_tx.sv
`timescale 1ns/1ps
`include "mio_defs.svh"

module mio_tx (
   input  logic                clk,
   input  logic                rst,
   input  logic                enable,       // CFG bit 0
   input  logic                access_in,
   input  emesh_pkg::packet_t  packet_in,
   output logic                wait_out,
   output logic                link_access,
   output mio_pkg::link_byte_t link_data,
   input  logic                link_wait,    // Stall from the receiver
   output logic                sent          // Final beat went out
);

   mio_pkg::tx_state_t state_q;
   mio_pkg::beat_t     beat_q;       // Beats sent so far
   logic [`MIO_PW-1:0] shift_q;      // Remaining bytes, LSB first

   logic accept;
   logic advance;
   logic last_beat;

   //########################################
   // Handshake
   //########################################

   // Busy or switched off
   assign wait_out = (state_q == mio_pkg::TX_SEND) | ~enable;
   assign accept   = access_in & ~wait_out;

   assign link_access = (state_q == mio_pkg::TX_SEND);
   assign link_data   = shift_q[`MIO_NMIO-1:0];   // Low byte on the wire

   // Beat counts only when the receiver takes it
   assign advance   = link_access & ~link_wait;
   assign last_beat = (beat_q == mio_pkg::beat_t'(`MIO_BEATS - 1));
   assign sent      = advance & last_beat;

   //########################################
   // FSM and beat count
   //########################################

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= mio_pkg::TX_IDLE;
         beat_q  <= '0;
      end else begin
         case (state_q)
            mio_pkg::TX_IDLE: begin
               if (accept) begin
                  state_q <= mio_pkg::TX_SEND;   // First beat next cycle
                  beat_q  <= '0;
               end
            end
            mio_pkg::TX_SEND: begin
               if (advance) begin
                  beat_q <= beat_q + 4'd1;
                  if (last_beat) begin
                     state_q <= mio_pkg::TX_IDLE;   // Ready for the next packet
                  end
               end
            end
            default: state_q <= mio_pkg::TX_IDLE;
         endcase
      end
   end

   // Packet shift register
   always_ff @(posedge clk) begin
      if (accept) begin
         shift_q <= packet_in;                   // Load whole packet
      end else if (advance) begin
         shift_q <= shift_q >> `MIO_NMIO;        // Next byte down
      end
   end

endmodule

// File: hdl/mio_rx.sv
`timescale 1ns/1ps
`include "mio_defs.svh"

module mio_rx (
   input  logic                clk,
   input  logic                rst,
   input  logic                link_access,
   input  mio_pkg::link_byte_t link_data,
   output logic                link_wait,
   output logic                access_out,
   output emesh_pkg::packet_t  packet_out,
   input  logic                wait_in
);

   mio_pkg::rx_state_t state_q;
   mio_pkg::beat_t     beat_q;   // Bytes collected
   emesh_pkg::packet_t pkt_q;    // Packet being rebuilt

   logic capture;
   logic last_beat;

   // Link is stalled for the whole hold
   assign link_wait  = (state_q == mio_pkg::RX_HOLD);
   assign capture    = link_access & ~link_wait;
   assign last_beat  = (beat_q == mio_pkg::beat_t'(`MIO_BEATS - 1));

   assign access_out = (state_q == mio_pkg::RX_HOLD);
   assign packet_out = pkt_q;

   //########################################
   // FSM
   //########################################

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= mio_pkg::RX_COLLECT;
         beat_q  <= '0;
      end else begin
         case (state_q)
            mio_pkg::RX_COLLECT: begin
               if (capture) begin
                  beat_q <= beat_q + 4'd1;
                  if (last_beat) begin
                     state_q <= mio_pkg::RX_HOLD;   // Present next cycle
                     beat_q  <= '0;
                  end
               end
            end
            mio_pkg::RX_HOLD: begin
               if (!wait_in) begin
                  state_q <= mio_pkg::RX_COLLECT;   // Taken by the mux
               end
            end
            default: state_q <= mio_pkg::RX_COLLECT;
         endcase
      end
   end

   // First byte ends up in the low bits after 13 shifts
   always_ff @(posedge clk) begin
      if (capture) begin
         pkt_q <= {link_data, pkt_q[`MIO_PW-1:`MIO_NMIO]};
      end
   end

endmodule

// File: hdl/mio_regs.sv
`timescale 1ns/1ps
`include "mio_defs.svh"

module mio_regs (
   input  logic               clk,
   input  logic               rst,
   input  logic               access_in,
   input  emesh_pkg::packet_t packet_in,
   output logic               wait_out,
   output logic               access_out,    // Read response valid
   output emesh_pkg::packet_t packet_out,
   input  logic               wait_in,
   output logic               enable,        // Transmit enable
   input  logic               sent           // Pulse per packet sent
);

   emesh_pkg::data_t   cfg_q;
   emesh_pkg::data_t   status_q;    // Sent packet count
   emesh_pkg::data_t   scratch_q;
   emesh_pkg::data_t   rd_data;
   emesh_pkg::packet_t resp_q;
   logic               resp_valid_q;

   logic       accept;
   logic       wr_en;
   logic       rd_en;
   logic [7:0] offset;

   // Stall only while an old response is stuck
   assign wait_out = resp_valid_q & wait_in;
   assign accept   = access_in & ~wait_out;
   assign wr_en    = accept & packet_in.write;
   assign rd_en    = accept & ~packet_in.write;
   assign offset   = packet_in.dstaddr[7:0];

   assign enable     = cfg_q[0];
   assign access_out = resp_valid_q;
   assign packet_out = resp_q;

   //########################################
   // Register file
   //########################################

   always_comb begin
      case (offset)
         `MIO_REG_CFG:     rd_data = cfg_q;
         `MIO_REG_STATUS:  rd_data = status_q;
         `MIO_REG_SCRATCH: rd_data = scratch_q;
         default:          rd_data = '0;   // Unmapped offset
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         cfg_q     <= `MIO_DEF_CFG;
         scratch_q <= '0;
      end else if (wr_en) begin
         case (offset)
            `MIO_REG_CFG:     cfg_q     <= packet_in.data;
            `MIO_REG_SCRATCH: scratch_q <= packet_in.data;
            default: ;                              // STATUS is read-only
         endcase
      end
   end

   // Counts packets fully out on the link
   always_ff @(posedge clk) begin
      if (rst) status_q <= '0;
      else if (sent) status_q <= status_q + 32'd1;
   end

   //########################################
   // Read response
   //########################################

   always_ff @(posedge clk) begin
      if (rst) resp_valid_q <= 1'b0;
      else if (rd_en) resp_valid_q <= 1'b1;       // New response wins
      else if (!wait_in) resp_valid_q <= 1'b0;    // Taken
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         resp_q         <= packet_in;              // Keep modes and srcaddr
         resp_q.write   <= 1'b1;
         resp_q.dstaddr <= packet_in.srcaddr;      // Back to requester
         resp_q.data    <= rd_data;
      end
   end

endmodule

// File: hdl/emesh_mux.sv
`timescale 1ns/1ps

module emesh_mux (
   input  logic               clk,
   input  logic               rst,
   input  logic [1:0]         access_in,     // Bit 0 has priority
   input  emesh_pkg::packet_t packet_in [2],
   output logic [1:0]         wait_out,
   output logic               access_out,
   output emesh_pkg::packet_t packet_out,
   input  logic               wait_in
);

   logic hold_q;   // Input 1 owns a stalled output
   logic sel;      // 1 picks input 1

   //########################################
   // Select
   //########################################

   // Input 1 only when 0 is idle, or when it is locked in
   assign sel = hold_q | ~access_in[0];

   assign access_out = access_in[sel];
   assign packet_out = packet_in[sel];

   // Per-input stall
   assign wait_out[0] = wait_in | hold_q;                   // Blocked by the lock
   assign wait_out[1] = wait_in | (access_in[0] & ~hold_q); // Blocked by input 0

   // Lock input 1 while its packet sits stalled on the output
   always_ff @(posedge clk) begin
      if (rst) begin
         hold_q <= 1'b0;
      end else begin
         hold_q <= sel & access_in[1] & wait_in;
      end
   end

endmodule

// File: hdl/mio_loop_top.sv
`timescale 1ns/1ps
`include "mio_defs.svh"

module mio_loop_top (
   input  logic               clk,
   input  logic               rst,
   input  logic               access_in,
   input  emesh_pkg::packet_t packet_in,
   output logic               wait_out,
   output logic               access_out,
   output emesh_pkg::packet_t packet_out,
   input  logic               wait_in
);

   // Decode
   logic link_path;
   logic mio_access;
   logic mio_wait;
   logic reg_access;
   logic reg_wait;

   // Loopback link
   logic                link_access;
   mio_pkg::link_byte_t link_data;
   logic                link_wait;

   // Register side
   logic tx_enable;
   logic tx_sent;

   // Mux inputs, 0 regs and 1 link
   logic [1:0]         mux_access;
   logic [1:0]         mux_wait;
   emesh_pkg::packet_t mux_packet [2];

   //########################################
   // Address decode
   //########################################

   assign link_path  = |packet_in.dstaddr[`MIO_AW-1:20];   // Nonzero goes to link
   assign mio_access = access_in & link_path;
   assign reg_access = access_in & ~link_path;
   assign wait_out   = link_path ? mio_wait : reg_wait;

   //########################################
   // Link path
   //########################################

   mio_tx tx (
      .clk         (clk),
      .rst         (rst),
      .enable      (tx_enable),
      .access_in   (mio_access),
      .packet_in   (packet_in),
      .wait_out    (mio_wait),
      .link_access (link_access),
      .link_data   (link_data),
      .link_wait   (link_wait),
      .sent        (tx_sent)
   );

   // Straight loopback of the tx side
   mio_rx rx (
      .clk         (clk),
      .rst         (rst),
      .link_access (link_access),
      .link_data   (link_data),
      .link_wait   (link_wait),
      .access_out  (mux_access[1]),
      .packet_out  (mux_packet[1]),
      .wait_in     (mux_wait[1])
   );

   //########################################
   // Register path and merge
   //########################################

   mio_regs regs (
      .clk        (clk),
      .rst        (rst),
      .access_in  (reg_access),
      .packet_in  (packet_in),
      .wait_out   (reg_wait),
      .access_out (mux_access[0]),
      .packet_out (mux_packet[0]),
      .wait_in    (mux_wait[0]),
      .enable     (tx_enable),
      .sent       (tx_sent)
   );

   emesh_mux mux (
      .clk        (clk),
      .rst        (rst),
      .access_in  (mux_access),
      .packet_in  (mux_packet),
      .wait_out   (mux_wait),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

endmodule

// File: tb/mio_loop_assertions.sv
`timescale 1ns/1ps

module mio_loop_assertions (
   input logic                clk,
   input logic                rst,
   input logic                access_out,
   input logic                wait_in,
   input emesh_pkg::packet_t  packet_out,
   input logic                link_access,
   input mio_pkg::link_byte_t link_data,
   input logic                link_wait
);

   //########################################
   // Mesh output and link stability
   //########################################

   // Stalled output keeps its packet
   a_out_stable: assert property (@(posedge clk) disable iff (rst)
      access_out && wait_in |=> access_out && $stable(packet_out))
      else $error("packet_out changed while stalled");

   // Stalled beat keeps its byte
   a_link_stable: assert property (@(posedge clk) disable iff (rst)
      link_access && link_wait |=> $stable(link_data))
      else $error("link_data changed during a link stall");

   a_reset_quiet: assert property (@(posedge clk) rst |=> !access_out)
      else $error("access_out high during reset");

endmodule

bind mio_loop_top mio_loop_assertions chk (
   .clk         (clk),
   .rst         (rst),
   .access_out  (access_out),
   .wait_in     (wait_in),
   .packet_out  (packet_out),
   .link_access (link_access),
   .link_data   (link_data),
   .link_wait   (link_wait)
);

// File: tb/mio_loop_tb.sv
`timescale 1ns/1ps
`include "mio_defs.svh"

module mio_loop_tb;

   localparam logic [1:0] K_LINK  = 2'd0;   // Loopback packet
   localparam logic [1:0] K_WRITE = 2'd1;   // Register write
   localparam logic [1:0] K_READ  = 2'd2;   // Register read
   localparam logic [1:0] K_HOLD  = 2'd3;   // Link packet with tx disabled
   localparam int NUM   = 18;
   localparam int LIMIT = NUM * 60;          // Cycle budget

   typedef struct packed {
      logic [1:0]         kind;
      logic               stall;   // Random wait_in during this entry
      emesh_pkg::data_t   exp;     // Read data
      emesh_pkg::packet_t pkt;
   } entry_t;

   logic               clk = 1'b0;
   logic               rst;
   logic               access_in;
   logic               wait_in = 1'b0;
   logic               wait_out;
   logic               access_out;
   emesh_pkg::packet_t packet_in;
   emesh_pkg::packet_t packet_out;

   entry_t             tbl [NUM];
   emesh_pkg::packet_t link_q [$];   // Expected link packets in order
   emesh_pkg::packet_t reg_q [$];    // Expected read responses
   emesh_pkg::packet_t exp_p;
   emesh_pkg::data_t   cfg_m;
   emesh_pkg::data_t   scratch_m;
   emesh_pkg::data_t   status_m;
   integer             seed = 32'h4c39d13e;
   logic [31:0]        rnd;
   logic               stall_on = 1'b0;
   int                 cycle = 0;
   int                 last_out = 0;   // Cycle of the latest output transfer
   int                 mism = 0;
   int                 other = 0;

   mio_loop_top uut (
      .clk        (clk),
      .rst        (rst),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   always #10 clk = ~clk;   // 20 ns period

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= LIMIT) begin
         $display("Error: timeout after %0d cycles with %0d link and %0d read outputs missing",
                  cycle, link_q.size(), reg_q.size());
         $display("Summary: %0d mismatches, %0d other errors", mism, other + 1);
         $display("Regression failed");
         $finish;
      end
   end

   // Random output back-pressure
   always @(posedge clk) begin
      rnd = $random(seed);
      wait_in <= stall_on & rnd[0];
   end

   //########################################
   // Table and reference model
   //########################################

   function automatic emesh_pkg::packet_t make_pkt(input emesh_pkg::addr_t src,
         input emesh_pkg::data_t data, input emesh_pkg::addr_t dst, input logic wr,
         input emesh_pkg::ctrl_t ctrl);
      emesh_pkg::packet_t p;
      p          = '0;
      p.srcaddr  = src;
      p.data     = data;
      p.dstaddr  = dst;
      p.ctrlmode = ctrl;
      p.datamode = 2'b10;   // Word
      p.write    = wr;
      return p;
   endfunction

   function automatic entry_t make_entry(input logic [1:0] kind, input logic stall,
         input emesh_pkg::data_t exp, input emesh_pkg::packet_t pkt);
      entry_t e;
      e.kind  = kind;
      e.stall = stall;
      e.exp   = exp;
      e.pkt   = pkt;
      return e;
   endfunction

   task automatic fill_table;
      emesh_pkg::addr_t cfg_a;
      emesh_pkg::addr_t stat_a;
      emesh_pkg::addr_t scr_a;
      cfg_a  = {24'h0, `MIO_REG_CFG};
      stat_a = {24'h0, `MIO_REG_STATUS};
      scr_a  = {24'h0, `MIO_REG_SCRATCH};
      tbl[0]  = make_entry(K_LINK, 0, 0,
                   make_pkt(32'h1234_5678, 32'h1122_3344, 32'h8100_0010, 1, 4'h3));
      tbl[1]  = make_entry(K_LINK, 0, 0,
                   make_pkt(32'h9abc_def0, 32'hdead_beef, 32'h0010_0000, 0, 4'h5));
      tbl[2]  = make_entry(K_WRITE, 0, 0, make_pkt(32'h0, 32'hcafe_f00d, scr_a, 1, 4'h0));
      tbl[3]  = make_entry(K_READ, 0, 32'hcafe_f00d, make_pkt(32'h0000_0a00, 0, scr_a, 0, 4'h2));
      tbl[4]  = make_entry(K_READ, 0, 0, make_pkt(32'h0000_0a04, 0, 32'h0000_000c, 0, 4'h1));
      tbl[5]  = make_entry(K_READ, 0, 2, make_pkt(32'h0000_0a08, 0, stat_a, 0, 4'h4));
      tbl[6]  = make_entry(K_READ, 0, 1, make_pkt(32'h0000_0a0c, 0, cfg_a, 0, 4'h6));
      tbl[7]  = make_entry(K_WRITE, 0, 0, make_pkt(32'h0, 32'h0, cfg_a, 1, 4'h0));
      tbl[8]  = make_entry(K_HOLD, 0, 0,
                   make_pkt(32'h5555_0000, 32'h0bad_cafe, 32'h4000_0030, 1, 4'h7));
      tbl[9]  = make_entry(K_WRITE, 0, 0, make_pkt(32'h0, 32'h1, cfg_a, 1, 4'h0));
      tbl[10] = make_entry(K_LINK, 0, 0, tbl[8].pkt);   // Same packet with tx enabled again
      tbl[11] = make_entry(K_LINK, 1, 0,
                   make_pkt(32'h0f0f_0f0f, 32'ha5a5_5a5a, 32'hfff0_0004, 1, 4'hf));
      tbl[12] = make_entry(K_READ, 1, 32'hcafe_f00d, make_pkt(32'h0000_0b00, 0, scr_a, 0, 4'h8));
      tbl[13] = make_entry(K_LINK, 1, 0,
                   make_pkt(32'h7777_1111, 32'h0123_4567, 32'h2220_0100, 0, 4'h9));
      tbl[14] = make_entry(K_WRITE, 1, 0, make_pkt(32'h0, 32'h5a5a_0001, scr_a, 1, 4'h0));
      tbl[15] = make_entry(K_READ, 1, 32'h5a5a_0001, make_pkt(32'h0000_0b04, 0, scr_a, 0, 4'ha));
      tbl[16] = make_entry(K_LINK, 1, 0,
                   make_pkt(32'h3c3c_c3c3, 32'h89ab_cdef, 32'h8000_0000, 1, 4'hb));
      tbl[17] = make_entry(K_READ, 1, 6, make_pkt(32'h0000_0b08, 0, stat_a, 0, 4'hc));
   endtask

   // Predicts the DUT's answers at each accepted request
   task automatic apply_model(input entry_t e);
      emesh_pkg::packet_t resp;
      emesh_pkg::data_t   rd;
      case (e.pkt.dstaddr[7:0])
         `MIO_REG_CFG:     rd = cfg_m;
         `MIO_REG_STATUS:  rd = status_m;
         `MIO_REG_SCRATCH: rd = scratch_m;
         default:          rd = '0;
      endcase
      if (e.kind == K_LINK) begin
         link_q.push_back(e.pkt);
         status_m = status_m + 32'd1;   // Counted by the time it is back
      end else if (e.kind == K_WRITE && e.pkt.dstaddr[7:0] == `MIO_REG_CFG) begin
         cfg_m = e.pkt.data;
      end else if (e.kind == K_WRITE && e.pkt.dstaddr[7:0] == `MIO_REG_SCRATCH) begin
         scratch_m = e.pkt.data;
      end else if (e.kind == K_READ) begin
         if (rd !== e.exp) begin
            other = other + 1;
            $display("Error: reference model and table disagree on read data");
         end
         resp         = e.pkt;
         resp.write   = 1'b1;
         resp.dstaddr = e.pkt.srcaddr;   // Back to the requester
         resp.data    = rd;
         reg_q.push_back(resp);
      end
   endtask

   //########################################
   // Output monitor
   //########################################

   task automatic compare_pkt(input emesh_pkg::packet_t expected);
      if (packet_out !== expected) begin
         mism = mism + 1;
         $display("Mismatch packet_out: got %h expected %h", packet_out, expected);
      end
   endtask

   // Read responses carry a requester address with zero top bits
   always @(negedge clk) begin
      if (!rst && access_out && !wait_in) begin
         if (packet_out.dstaddr[31:20] != 12'h0) begin
            if (link_q.size() == 0) begin
               other = other + 1;
               $display("Error: link packet on the output with none outstanding");
            end else begin
               exp_p = link_q.pop_front();
               compare_pkt(exp_p);
            end
         end else if (reg_q.size() == 0) begin
            other = other + 1;
            $display("Error: read response on the output with no read outstanding");
         end else begin
            exp_p = reg_q.pop_front();
            compare_pkt(exp_p);
         end
         last_out = cycle;
      end
   end

   //########################################
   // Stimulus
   //########################################

   task automatic run_entry(input int i);
      entry_t e;
      int     acc_cycle;
      logic   accepted;
      e         = tbl[i];
      acc_cycle = 0;
      if (e.kind == K_READ && e.pkt.dstaddr[7:0] == `MIO_REG_STATUS) begin
         while (link_q.size() != 0) @(posedge clk);   // Count final once all are back
      end
      @(posedge clk);
      stall_on  <= e.stall;
      access_in <= 1'b1;
      packet_in <= e.pkt;
      if (e.kind == K_HOLD) begin
         repeat (20) begin
            @(negedge clk);
            if (!wait_out) begin
               other = other + 1;
               $display("Error: link packet accepted while transmit is disabled");
            end
         end
      end else begin
         accepted = 1'b0;
         while (!accepted) begin
            @(negedge clk);
            accepted = !wait_out;   // Transfer on the coming edge
         end
         acc_cycle = cycle;
         apply_model(e);
      end
      @(posedge clk);
      access_in <= 1'b0;   // Held entry is withdrawn here
      // Stalled link packets stay in flight under the entries that follow
      if (e.kind == K_READ) begin
         while (reg_q.size() != 0) @(posedge clk);
      end else if (e.kind == K_LINK && !e.stall) begin
         while (link_q.size() != 0) @(posedge clk);
         if (last_out - acc_cycle != 14) begin
            mism = mism + 1;
            $display("Mismatch link latency: got %h expected %h", last_out - acc_cycle, 14);
         end
      end
   endtask

   initial begin
      rst       = 1'b1;
      access_in = 1'b0;
      packet_in = '0;
      cfg_m     = `MIO_DEF_CFG;
      scratch_m = '0;
      status_m  = '0;
      fill_table();
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < NUM; i++) begin
         run_entry(i);
      end
      repeat (4) @(posedge clk);   // Room for a stray duplicate to show
      $display("Summary: %0d mismatches, %0d other errors", mism, other);
      if (mism + other == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: mio_loop_top.f
+incdir+include
hdl/emesh_pkg.sv
hdl/mio_pkg.sv
hdl/mio_tx.sv
hdl/mio_rx.sv
hdl/mio_regs.sv
hdl/emesh_mux.sv
hdl/mio_loop_top.sv
tb/mio_loop_assertions.sv
tb/mio_loop_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the mio_loop regression with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module mio_loop_tb -f mio_loop_top.f \
   --Mdir obj_dir -o mio_loop_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/mio_loop_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
   exit 0
fi
exit 1
